// File: project.f
design/sound_pkg.sv
design/game_pkg.sv
design/flash_port.sv
design/fir31.sv
design/music_stream.sv
design/effect_bank.sv
design/sound_mixer.sv
design/sound_top.sv
verif/sound_assertions.sv
verif/sound_tb.sv

// File: verif/sound_tb.sv
`timescale 1ns/1ps

module sound_tb;

	//////////////////////////////
	// test setup
	//////////////////////////////

	localparam int CLOCK_PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	localparam int READY_PERIOD = 64; // twice the filter's 32 cycle minimum
	localparam int LOAD_LIMIT = 2000; // cycles allowed for the clip copy

	// small address map so every range is walked quickly
	localparam game_pkg::flash_addr_t MUSIC_START = 23'h40;
	localparam game_pkg::flash_addr_t MUSIC_END = 23'h4f;
	localparam game_pkg::flash_addr_t POPUP_START = 23'h10;
	localparam game_pkg::flash_addr_t POPUP_END = 23'h13;
	localparam game_pkg::flash_addr_t MISSED_START = 23'h20;
	localparam game_pkg::flash_addr_t MISSED_END = 23'h25;
	localparam game_pkg::flash_addr_t WHACKED_START = 23'h30;
	localparam game_pkg::flash_addr_t WHACKED_END = 23'h32;

	localparam game_pkg::flash_word_t MUSIC_LEVEL = 16'ha550; // high byte is never a sample
	localparam int COEFF_SUM = 1022; // dc gain of the low-pass in 1/1024 units

	localparam int IDLE_STROBES = 8;
	localparam int MUSIC_STROBES = 40; // history holds only the level by then
	localparam int LOOP_STROBES = 20;  // more than one lap of the tune
	localparam int FLUSH_STROBES = 40;
	localparam int TAIL_STROBES = 2;   // silent strobes after each clip
	localparam int CLIP_WORDS = (POPUP_END - POPUP_START + 1)
		+ (MISSED_END - MISSED_START + 1) + (WHACKED_END - WHACKED_START + 1);
	localparam int TEST_STROBES = IDLE_STROBES + MUSIC_STROBES + LOOP_STROBES
		+ FLUSH_STROBES + CLIP_WORDS + 3 * TAIL_STROBES + 9; // 9 syncs between tests
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + LOAD_LIMIT
		+ (TEST_STROBES + 20) * READY_PERIOD;

	logic clock;
	logic reset;
	logic ready;
	game_pkg::game_state_t game_state;
	logic flash_busy;
	game_pkg::flash_word_t flash_data;
	logic flash_read;
	game_pkg::flash_addr_t flash_address;
	sound_pkg::sample_t to_ac97_data;

	game_pkg::flash_word_t music_word;  // what the flash holds in the music range
	game_pkg::flash_addr_t read_log[$]; // every address the DUT read
	game_pkg::flash_addr_t read_address;
	logic start_read;                   // busy rises on the next cycle
	int busy_left;
	logic [31:0] rand_state;
	int ready_count;
	int value_errors;
	int other_errors;
	int assertion_errors;

	sound_top #(
		.MUSIC_START(MUSIC_START),
		.MUSIC_END(MUSIC_END),
		.POPUP_START(POPUP_START),
		.POPUP_END(POPUP_END),
		.MISSED_START(MISSED_START),
		.MISSED_END(MISSED_END),
		.WHACKED_START(WHACKED_START),
		.WHACKED_END(WHACKED_END),
		.CLIP_LOGSIZE(8)
	) u_sound_top (
		.clock(clock),
		.reset(reset),
		.ready(ready),
		.game_state(game_state),
		.flash_busy(flash_busy),
		.flash_data(flash_data),
		.flash_read(flash_read),
		.flash_address(flash_address),
		.to_ac97_data(to_ac97_data)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// codec ready pulse once every READY_PERIOD cycles
	always @(negedge clock) begin
		ready = (ready_count == READY_PERIOD - 1);
		ready_count = (ready_count + 1) % READY_PERIOD;
	end

	//////////////////////////////
	// flash model
	//////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		lcg_next = state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic game_pkg::flash_word_t flash_word(input game_pkg::flash_addr_t address);
		if (address >= MUSIC_START && address <= MUSIC_END)
			flash_word = music_word;
		else
			flash_word = {8'h5a, address[7:0]}; // clip words carry their address low byte
	endfunction

	always @(negedge clock) begin
		if (busy_left != 0) begin
			busy_left = busy_left - 1;
			if (busy_left == 0) begin
				flash_busy = 1'b0;
				flash_data = flash_word(read_address); // valid with busy low
			end
		end
		if (start_read) begin
			start_read = 1'b0;
			rand_state = lcg_next(rand_state);
			busy_left = 2 + rand_state[23:16] % 7; // 2 to 8 cycles
			flash_busy = 1'b1;
		end
		if (flash_read === 1'b1) begin
			start_read = 1'b1;
			read_address = flash_address;
			read_log.push_back(flash_address);
		end
	end

	//////////////////////////////
	// helpers and checks
	//////////////////////////////

	// returns at the rising edge that samples ready high
	task automatic wait_strobe();
		do
			@(posedge clock);
		while (ready !== 1'b1);
	endtask

	// codec sample registered on the next strobe
	task automatic next_output(output sound_pkg::sample_t value);
		wait_strobe();
		@(negedge clock);
		value = to_ac97_data;
	endtask

	task automatic check_sample(input string test_name, input sound_pkg::sample_t expected,
		input sound_pkg::sample_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("ERROR %s: expected %h, actual %h", test_name, expected, actual);
		end
	endtask

	task automatic check_address(input string test_name, input game_pkg::flash_addr_t expected,
		input game_pkg::flash_addr_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("ERROR %s: expected %h, actual %h", test_name, expected, actual);
		end
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////

	// clips are copied in map order right after reset
	task automatic loading_order();
		game_pkg::flash_addr_t expected[$];
		game_pkg::flash_addr_t address;
		int cycles;
		for (address = POPUP_START; address <= POPUP_END; address++)
			expected.push_back(address);
		for (address = MISSED_START; address <= MISSED_END; address++)
			expected.push_back(address);
		for (address = WHACKED_START; address <= WHACKED_END; address++)
			expected.push_back(address);
		cycles = 0;
		while (read_log.size() < expected.size() && cycles < LOAD_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		repeat (50) @(posedge clock); // any extra read would show up here
		if (read_log.size() != expected.size()) begin
			other_errors++;
			$display("loading: saw %0d flash reads where %0d clip words were expected",
				read_log.size(), expected.size());
		end
		for (int i = 0; i < expected.size() && i < read_log.size(); i++)
			check_address("loading", expected[i], read_log[i]);
	endtask

	// the filter still holds the music level while the codec stays silent
	task automatic idle_silence();
		sound_pkg::sample_t value;
		wait_strobe();
		@(negedge clock);
		game_state = game_pkg::IDLE;
		wait_strobe(); // last music read is back by now
		read_log.delete();
		repeat (IDLE_STROBES) begin
			next_output(value);
			check_sample("idle", 8'sd0, value);
		end
		@(posedge clock);
		if (read_log.size() != 0) begin
			other_errors++;
			$display("idle: music was read from flash %0d times while idle", read_log.size());
		end
	endtask

	// a constant music word settles at the filter's dc gain
	task automatic music_level();
		sound_pkg::sample_t value;
		sound_pkg::sample_t expected;
		int level;
		level = COEFF_SUM * int'(sound_pkg::sample_t'(MUSIC_LEVEL[7:0]));
		expected = sound_pkg::sample_t'(level >>> 10);
		wait_strobe();
		music_word = MUSIC_LEVEL;
		@(negedge clock);
		game_state = game_pkg::GAME_ONGOING;
		repeat (MUSIC_STROBES) next_output(value);
		check_sample("music level", expected, value);
	endtask

	// each strobe reads the next music word and wraps at the end
	task automatic music_wrap();
		game_pkg::flash_addr_t expected;
		wait_strobe();
		@(negedge clock);
		game_state = game_pkg::IDLE; // tune restarts from MUSIC_START
		wait_strobe();
		read_log.delete();
		@(negedge clock);
		game_state = game_pkg::GAME_ONGOING;
		repeat (LOOP_STROBES) wait_strobe();
		repeat (16) @(posedge clock);
		if (read_log.size() < MUSIC_END - MUSIC_START + 2) begin
			other_errors++;
			$display("music loop: only %0d music reads, too few to wrap", read_log.size());
		end
		expected = MUSIC_START;
		for (int i = 0; i < read_log.size(); i++) begin
			expected = (expected == MUSIC_END) ? MUSIC_START : expected + 23'd1;
			check_address("music loop", expected, read_log[i]);
		end
	endtask

	task automatic play_clip(input string test_name, input game_pkg::game_state_t state,
		input game_pkg::flash_addr_t first, input game_pkg::flash_addr_t last);
		sound_pkg::sample_t value;
		game_pkg::flash_addr_t address;
		wait_strobe();
		@(negedge clock);
		game_state = state; // entered just after a strobe
		for (address = first; address <= last; address++) begin
			next_output(value);
			check_sample(test_name, sound_pkg::sample_t'(address[7:0]), value);
		end
		repeat (TAIL_STROBES) begin
			next_output(value);
			check_sample(test_name, 8'sd0, value); // music is silent once the clip is over
		end
		@(negedge clock);
		game_state = game_pkg::GAME_ONGOING;
	endtask

	task automatic clip_playback();
		sound_pkg::sample_t value;
		wait_strobe();
		music_word = '0;
		repeat (FLUSH_STROBES) next_output(value); // drain the old level from the filter
		check_sample("clip flush", 8'sd0, value);
		play_clip("popup clip", game_pkg::MOLE_COUNTDOWN, POPUP_START, POPUP_END);
		play_clip("missed clip", game_pkg::MOLE_MISSED_SOUND, MISSED_START, MISSED_END);
		play_clip("whacked clip", game_pkg::MOLE_WHACKED_SOUND, WHACKED_START, WHACKED_END);
	endtask

	//////////////////////////////
	// run control
	//////////////////////////////

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		ready = 1'b0;
		game_state = game_pkg::IDLE;
		flash_busy = 1'b0;
		flash_data = '0;
		music_word = '0;
		read_address = '0;
		start_read = 1'b0;
		busy_left = 0;
		rand_state = 32'he531;
		ready_count = 0;
		value_errors = 0;
		other_errors = 0;
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;
		loading_order();
		music_level();
		idle_silence();
		music_wrap();
		clip_playback();
		assertion_errors = u_sound_top.u_sound_assertions.failures;
		$display("errors: %0d wrong values, %0d other failures, %0d assertion failures",
			value_errors, other_errors, assertion_errors);
		if (value_errors + other_errors + assertion_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// ends a stuck run
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: verif/sound_assertions.sv
`timescale 1ns/1ps

// flash handshake and idle silence, bound into sound_top
module sound_assertions (
	input logic clock,
	input logic reset,
	input logic ready,
	input game_pkg::game_state_t game_state,
	input logic flash_busy,
	input logic flash_read,
	input sound_pkg::sample_t to_ac97_data
);

	int failures = 0; // summed into the testbench totals

	// manager must be idle when a read goes out
	read_when_idle: assert property (@(posedge clock) disable iff (reset)
		flash_read |-> !flash_busy)
		else begin
			failures++;
			$error("flash_read issued while flash_busy is high");
		end

	read_one_cycle: assert property (@(posedge clock) disable iff (reset)
		flash_read |=> !flash_read) // strobe, never a level
		else begin
			failures++;
			$error("flash_read held longer than one cycle");
		end

	// codec gets silence between games
	idle_silent: assert property (@(posedge clock) disable iff (reset)
		(ready && game_state == game_pkg::IDLE) |=> (to_ac97_data == 8'sd0))
		else begin
			failures++;
			$error("to_ac97_data not zero after a ready strobe in IDLE");
		end

endmodule

bind sound_top sound_assertions u_sound_assertions (
	.clock(clock),
	.reset(reset),
	.ready(ready),
	.game_state(game_state),
	.flash_busy(flash_busy),
	.flash_read(flash_read),
	.to_ac97_data(to_ac97_data)
);

// File: design/sound_top.sv
`timescale 1ns/1ps

// sound engine: music and clips side by side, mixed into the codec stream
module sound_top #(
	parameter game_pkg::flash_addr_t MUSIC_START = 23'h3000,
	parameter game_pkg::flash_addr_t MUSIC_END = 23'h6AC00,
	parameter game_pkg::flash_addr_t POPUP_START = 23'h83000,
	parameter game_pkg::flash_addr_t POPUP_END = 23'h83500,
	parameter game_pkg::flash_addr_t MISSED_START = 23'h8C000,
	parameter game_pkg::flash_addr_t MISSED_END = 23'h8CD00,
	parameter game_pkg::flash_addr_t WHACKED_START = 23'h92A00,
	parameter game_pkg::flash_addr_t WHACKED_END = 23'h93000,
	parameter int CLIP_LOGSIZE = 16
) (
	input logic clock,
	input logic reset,
	input logic ready,                       // codec strobe
	input game_pkg::game_state_t game_state,
	input logic flash_busy,
	input game_pkg::flash_word_t flash_data,
	output logic flash_read,
	output game_pkg::flash_addr_t flash_address,
	output sound_pkg::sample_t to_ac97_data
);

	logic load_request;
	logic music_request;
	logic loaded; // clips in memory, flash belongs to music
	game_pkg::flash_addr_t load_address;
	game_pkg::flash_addr_t music_address;
	game_pkg::flash_word_t read_data;
	logic data_valid;
	sound_pkg::sample_t music_sample;
	sound_pkg::sample_t effect_sample;
	logic effect_active;

	flash_port u_flash_port (
		.clock(clock),
		.reset(reset),
		.load_request(load_request),
		.music_request(music_request),
		.loaded(loaded),
		.load_address(load_address),
		.music_address(music_address),
		.flash_busy(flash_busy),
		.flash_data(flash_data),
		.flash_read(flash_read),
		.flash_address(flash_address),
		.read_data(read_data),
		.data_valid(data_valid)
	);

	music_stream #(
		.MUSIC_START(MUSIC_START),
		.MUSIC_END(MUSIC_END)
	) u_music_stream (
		.clock(clock),
		.reset(reset),
		.ready(ready),
		.loaded(loaded),
		.game_state(game_state),
		.read_data(read_data),
		.data_valid(data_valid),
		.music_request(music_request),
		.music_address(music_address),
		.music_sample(music_sample)
	);

	effect_bank #(
		.POPUP_START(POPUP_START),
		.POPUP_END(POPUP_END),
		.MISSED_START(MISSED_START),
		.MISSED_END(MISSED_END),
		.WHACKED_START(WHACKED_START),
		.WHACKED_END(WHACKED_END),
		.CLIP_LOGSIZE(CLIP_LOGSIZE)
	) u_effect_bank (
		.clock(clock),
		.reset(reset),
		.ready(ready),
		.game_state(game_state),
		.read_data(read_data),
		.data_valid(data_valid),
		.load_request(load_request),
		.load_address(load_address),
		.loaded(loaded),
		.effect_sample(effect_sample),
		.effect_active(effect_active)
	);

	sound_mixer u_sound_mixer (
		.clock(clock),
		.reset(reset),
		.ready(ready),
		.game_state(game_state),
		.music_sample(music_sample),
		.effect_sample(effect_sample),
		.effect_active(effect_active),
		.to_ac97_data(to_ac97_data)
	);

endmodule

// File: design/sound_mixer.sv
`timescale 1ns/1ps

// codec sample, registered on each ready strobe
module sound_mixer (
	input logic clock,
	input logic reset,
	input logic ready,
	input game_pkg::game_state_t game_state,
	input sound_pkg::sample_t music_sample,
	input sound_pkg::sample_t effect_sample,
	input logic effect_active,
	output sound_pkg::sample_t to_ac97_data
);

	sound_pkg::sample_t effect_part; // clip contribution, zero when no clip plays
	sound_pkg::sample_t mix;

	assign effect_part = effect_active ? effect_sample : 8'sd0;
	assign mix = music_sample + effect_part; // 8 bit, wraps on overflow

	always_ff @(posedge clock) begin
		if (reset) begin
			to_ac97_data <= '0;
		end else if (ready) begin
			if (game_state == game_pkg::IDLE)
				to_ac97_data <= '0; // silent between games
			else
				to_ac97_data <= mix;
		end
	end

endmodule

// File: design/effect_bank.sv
`timescale 1ns/1ps

// copies the three clips from flash into block memory at start-up,
// then plays one of them each time the game enters a mole state
module effect_bank #(
	parameter game_pkg::flash_addr_t POPUP_START = 23'h83000,
	parameter game_pkg::flash_addr_t POPUP_END = 23'h83500,
	parameter game_pkg::flash_addr_t MISSED_START = 23'h8C000,
	parameter game_pkg::flash_addr_t MISSED_END = 23'h8CD00,
	parameter game_pkg::flash_addr_t WHACKED_START = 23'h92A00,
	parameter game_pkg::flash_addr_t WHACKED_END = 23'h93000,
	parameter int CLIP_LOGSIZE = 16
) (
	input logic clock,
	input logic reset,
	input logic ready,
	input game_pkg::game_state_t game_state,
	input game_pkg::flash_word_t read_data,
	input logic data_valid,
	output logic load_request,
	output game_pkg::flash_addr_t load_address,
	output logic loaded,
	output sound_pkg::sample_t effect_sample,
	output logic effect_active
);

	typedef logic [CLIP_LOGSIZE-1:0] clip_addr_t;

	// loader
	game_pkg::load_state_t load_state;
	logic waiting;                              // flash read outstanding
	logic load_word;                            // a clip word came back
	game_pkg::flash_addr_t clip_start_address;  // flash bounds of current clip
	game_pkg::flash_addr_t clip_end_address;
	logic [1:0] load_clip;
	clip_addr_t fill;                           // next free memory slot
	logic write_enable;
	clip_addr_t write_address;
	sound_pkg::sample_t write_data;
	sound_pkg::sample_t clip_mem [2**CLIP_LOGSIZE];
	clip_addr_t clip_first [3];                 // memory bounds per clip
	clip_addr_t clip_last [3];

	// playback
	game_pkg::game_state_t last_state;
	logic new_clip;                             // entered a state with a clip
	logic [1:0] play_clip;
	clip_addr_t play_ptr;
	clip_addr_t play_end;

	//////////////////////////////
	// clip loader
	//////////////////////////////

	always_comb begin
		case (load_state)
			game_pkg::LOAD_POP: begin
				clip_start_address = POPUP_START;
				clip_end_address = POPUP_END;
				load_clip = 2'd0;
			end
			game_pkg::LOAD_MISSED: begin
				clip_start_address = MISSED_START;
				clip_end_address = MISSED_END;
				load_clip = 2'd1;
			end
			default: begin // whacked, done never uses these
				clip_start_address = WHACKED_START;
				clip_end_address = WHACKED_END;
				load_clip = 2'd2;
			end
		endcase
	end

	assign load_word = data_valid && waiting && (load_state != game_pkg::LOAD_DONE);

	always_ff @(posedge clock) begin
		if (reset) begin
			load_state <= game_pkg::LOAD_POP;
			load_address <= POPUP_START;
			load_request <= 1'b0;
			waiting <= 1'b0;
			fill <= '0;
			write_enable <= 1'b0;
			loaded <= 1'b0;
		end else begin
			load_request <= 1'b0;
			write_enable <= load_word; // memory write one cycle after data_valid
			if (load_state == game_pkg::LOAD_DONE) begin
				loaded <= 1'b1; // last whacked word is in memory by now
			end else if (!waiting) begin
				load_request <= 1'b1;
				waiting <= 1'b1;
			end else if (load_word) begin
				waiting <= 0;
				fill <= fill + 1'b1;
				if (load_address == clip_end_address) begin
					// clips go back to back in memory
					case (load_state)
						game_pkg::LOAD_POP: begin
							load_state <= game_pkg::LOAD_MISSED;
							load_address <= MISSED_START;
						end
						game_pkg::LOAD_MISSED: begin
							load_state <= game_pkg::LOAD_WHACKED;
							load_address <= WHACKED_START;
						end
						default: load_state <= game_pkg::LOAD_DONE;
					endcase
				end else begin
					load_address <= load_address + 23'd1;
				end
			end
		end
	end

	// word capture and clip bounds
	always_ff @(posedge clock) begin
		if (load_word) begin
			write_address <= fill;
			write_data <= read_data[7:0];
			if (load_address == clip_start_address)
				clip_first[load_clip] <= fill;
			clip_last[load_clip] <= fill; // ends on the clip's final word
		end
		if (new_clip)
			play_end <= clip_last[play_clip];
	end

	// block memory, one write and one registered read port
	always_ff @(posedge clock) begin
		if (write_enable)
			clip_mem[write_address] <= write_data;
		effect_sample <= clip_mem[play_ptr]; // one cycle read latency
	end

	//////////////////////////////
	// clip playback
	//////////////////////////////

	always_comb begin
		new_clip = 1'b0;
		play_clip = 2'd0;
		if (loaded && (game_state != last_state)) begin
			case (game_state)
				game_pkg::MOLE_COUNTDOWN: begin
					new_clip = 1'b1;
					play_clip = 2'd0; // pop-up
				end
				game_pkg::MOLE_MISSED_SOUND: begin
					new_clip = 1'b1;
					play_clip = 2'd1;
				end
				game_pkg::MOLE_WHACKED_SOUND: begin
					new_clip = 1'b1;
					play_clip = 2'd2;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			last_state <= game_pkg::IDLE;
			play_ptr <= '0;
			effect_active <= 1'b0;
		end else begin
			last_state <= game_state;
			if (new_clip) begin
				play_ptr <= clip_first[play_clip]; // restarts even mid clip
				effect_active <= 1'b1;
			end else if (game_state == game_pkg::IDLE) begin
				effect_active <= 1'b0;
			end else if (ready && effect_active) begin
				if (play_ptr == play_end)
					effect_active <= 1'b0; // last byte went out on this strobe
				else
					play_ptr <= play_ptr + 1'b1;
			end
		end
	end

endmodule

// File: design/music_stream.sv
`timescale 1ns/1ps

// looping background music from flash, low-pass filtered
module music_stream #(
	parameter game_pkg::flash_addr_t MUSIC_START = 23'h3000,
	parameter game_pkg::flash_addr_t MUSIC_END = 23'h6AC00
) (
	input logic clock,
	input logic reset,
	input logic ready,
	input logic loaded,
	input game_pkg::game_state_t game_state,
	input game_pkg::flash_word_t read_data,
	input logic data_valid,
	output logic music_request,
	output game_pkg::flash_addr_t music_address,
	output sound_pkg::sample_t music_sample
);

	logic playing;                     // flash is ours and the game runs
	logic feed;                        // one filter step per codec strobe
	logic outstanding;                 // read issued, word not back yet
	game_pkg::flash_word_t music_word; // last word returned by flash
	sound_pkg::sample_t filter_x;
	sound_pkg::acc_t filter_y;

	assign playing = loaded && (game_state != game_pkg::IDLE);
	assign feed = ready && playing;
	assign filter_x = music_word[7:0];    // low byte holds the pcm sample
	assign music_sample = filter_y[17:10]; // undo the 2**10 coefficient scale

	always_ff @(posedge clock) begin
		if (reset) begin
			music_request <= 1'b0;
			music_address <= MUSIC_START;
			outstanding <= 1'b0;
			music_word <= '0; // filter sees silence until the first word
		end else begin
			music_request <= 1'b0;
			if (data_valid && loaded) begin
				music_word <= read_data;
				outstanding <= 1'b0;
			end
			if (game_state == game_pkg::IDLE) begin
				music_address <= MUSIC_START; // restart the tune next game
			end else if (feed) begin
				// wrap at the end of the tune
				if (music_address >= MUSIC_END)
					music_address <= MUSIC_START;
				else
					music_address <= music_address + 23'd1;
				if (!outstanding) begin
					music_request <= 1'b1; // fetch the new address
					outstanding <= 1'b1;
				end
			end
		end
	end

	fir31 u_fir31 (
		.clock(clock),
		.reset(reset),
		.ready(feed),
		.x(filter_x),
		.y(filter_y)
	);

endmodule

// File: design/fir31.sv
`timescale 1ns/1ps

// 31 tap low-pass, one multiply-accumulate per clock after each ready
// y is the sum scaled by 2**10, take y[17:10] for the audible byte
module fir31 (
	input logic clock,
	input logic reset,
	input logic ready,
	input sound_pkg::sample_t x,
	output sound_pkg::acc_t y
);

	localparam int DEPTH = 32; // power of two so the history pointer wraps by itself

	sound_pkg::sample_t history [DEPTH]; // circular sample history
	sound_pkg::tap_t offset;              // next slot to write
	sound_pkg::tap_t index;               // tap being summed, TAPS when idle
	sound_pkg::tap_t read_ptr;
	sound_pkg::coeff_t coeff;
	sound_pkg::acc_t product;
	sound_pkg::acc_t sum;

	//////////////////////////////
	// coefficient rom
	//////////////////////////////

	// round(fir1(30,.125)*1024), symmetric so only half is stored
	function automatic sound_pkg::coeff_t coeff_rom(input sound_pkg::tap_t tap);
		sound_pkg::tap_t fold;
		fold = (tap > 5'd15) ? sound_pkg::tap_t'(5'd30 - tap) : tap;
		case (fold)
			5'd0:    coeff_rom = -10'sd1;
			5'd1:    coeff_rom = -10'sd1;
			5'd2:    coeff_rom = -10'sd3;
			5'd3:    coeff_rom = -10'sd5;
			5'd4:    coeff_rom = -10'sd6;
			5'd5:    coeff_rom = -10'sd7;
			5'd6:    coeff_rom = -10'sd5;
			5'd7:    coeff_rom = 10'sd0;
			5'd8:    coeff_rom = 10'sd10;
			5'd9:    coeff_rom = 10'sd26;
			5'd10:   coeff_rom = 10'sd46;
			5'd11:   coeff_rom = 10'sd69;
			5'd12:   coeff_rom = 10'sd91;
			5'd13:   coeff_rom = 10'sd110;
			5'd14:   coeff_rom = 10'sd123;
			5'd15:   coeff_rom = 10'sd128; // centre tap
			default: coeff_rom = 10'sd0;
		endcase
	endfunction

	//////////////////////////////
	// multiply-accumulate
	//////////////////////////////

	assign read_ptr = offset - 5'd1 - index; // newest sample is at offset-1
	assign coeff = coeff_rom(index);
	assign product = coeff * history[read_ptr]; // signed, extended to 18 bits

	always_ff @(posedge clock) begin
		if (reset) begin
			offset <= '0;
			index <= sound_pkg::tap_t'(sound_pkg::TAPS);
			sum <= '0;
			y <= '0;
			for (int i = 0; i < DEPTH; i++)
				history[i] <= '0; // start from silence
		end else if (ready) begin
			history[offset] <= x;
			offset <= offset + 5'd1;
			index <= '0;
			sum <= '0;
		end else if (index != sound_pkg::TAPS) begin
			index <= index + 5'd1;
			sum <= sum + product;
			if (index == sound_pkg::TAPS - 1)
				y <= sum + product; // last tap, 32 cycles after ready
		end
	end

endmodule

// File: design/flash_port.sv
`timescale 1ns/1ps

// one flash, two users: the clip loader until loaded, the music stream after
module flash_port (
	input logic clock,
	input logic reset,
	input logic load_request,
	input logic music_request,
	input logic loaded,
	input game_pkg::flash_addr_t load_address,
	input game_pkg::flash_addr_t music_address,
	input logic flash_busy,
	input game_pkg::flash_word_t flash_data,
	output logic flash_read,
	output game_pkg::flash_addr_t flash_address,
	output game_pkg::flash_word_t read_data,
	output logic data_valid
);

	logic request;                           // request of the active user
	game_pkg::flash_addr_t request_address;
	logic pending;                           // request seen, read not issued yet
	game_pkg::flash_addr_t pending_address;
	logic in_flight;                         // read issued, data not back
	logic busy_seen;                         // manager has raised busy for it
	logic issue;
	logic capture;

	// loaded picks the owner, the other side is simply ignored
	assign request = loaded ? music_request : load_request;
	assign request_address = loaded ? music_address : load_address;

	assign issue = pending && !in_flight && !flash_busy; // only while the manager is idle
	assign capture = in_flight && busy_seen && !flash_busy; // first idle cycle, data is valid

	always_ff @(posedge clock) begin
		if (reset) begin
			flash_read <= 1'b0;
			data_valid <= 1'b0;
			pending <= 1'b0;
			in_flight <= 1'b0;
			busy_seen <= 1'b0;
		end else begin
			flash_read <= issue;   // single cycle read strobe
			data_valid <= capture; // single cycle, one after busy falls
			if (issue) begin
				pending <= 1'b0;
				in_flight <= 1'b1;
			end
			if (request)
				pending <= 1'b1; // users wait for data_valid, so no overrun
			if (in_flight && flash_busy)
				busy_seen <= 1'b1;
			if (capture) begin
				in_flight <= 1'b0;
				busy_seen <= 1'b0;
			end
		end
	end

	// address and data registers
	always_ff @(posedge clock) begin
		if (request)
			pending_address <= request_address;
		if (issue)
			flash_address <= pending_address;
		if (capture)
			read_data <= flash_data;
	end

endmodule

// File: design/game_pkg.sv
package game_pkg;

	//////////////////////////////
	// game controller states
	//////////////////////////////

	// codes come from the game controller, keep them fixed
	typedef enum logic [3:0] {
		IDLE               = 4'd0,  // waiting for start, sound is silent
		GAME_ONGOING       = 4'd2,
		REQUEST_MOLE       = 4'd3,  // one cycle pulse state
		MOLE_COUNTDOWN     = 4'd4,  // mole shown, pop-up clip
		MOLE_MISSED        = 4'd5,
		MOLE_WHACKED       = 4'd6,
		MOLE_MISSED_SOUND  = 4'd9,  // extra time for the missed clip
		MOLE_WHACKED_SOUND = 4'd10  // extra time for the whacked clip
	} game_state_t;

	// clip loader, one state per clip then done
	typedef enum logic [1:0] {
		LOAD_POP,
		LOAD_MISSED,
		LOAD_WHACKED,
		LOAD_DONE
	} load_state_t;

	typedef logic [22:0] flash_addr_t; // flash word address
	typedef logic [15:0] flash_word_t; // flash data word, low byte is the sample

endpackage

// File: design/sound_pkg.sv
package sound_pkg;

	//////////////////////////////
	// audio data path types
	//////////////////////////////

	// signed pcm byte, codec and clip memory width
	typedef logic signed [7:0] sample_t;

	// filter accumulator, result is scaled by 2**10
	// so the audible byte sits in bits 17:10
	typedef logic signed [17:0] acc_t;

	typedef logic signed [9:0] coeff_t; // low-pass coefficient, scaled by 2**10

	typedef logic [4:0] tap_t; // index into the tap table / sample history

	// number of taps in the low-pass filter
	parameter int TAPS = 31;

endpackage
